// File: design/mem_front_pkg.sv
package mem_front_pkg;

    // byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // one beat of the burst port, two words
    typedef logic [63:0] beat_t;

    // one line, eight words
    typedef logic [255:0] line_t;

    // upper address bits naming a line
    typedef logic [26:0] line_tag_t;

    // word index inside a line
    typedef logic [2:0] word_sel_t;

    localparam int BEATS_PER_LINE = 4;

    typedef enum logic [1:0] {
        idle,
        request,
        collect
    } deser_state_t;

    typedef enum logic [1:0] {
        none,
        grant_load,
        grant_fetch
    } grant_t;

endpackage

// File: design/burst_deserializer.sv
`timescale 1ns/1ps

module burst_deserializer
import mem_front_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    start_i,
    input  addr_t   start_addr_i,

    input  logic    bmem_ready_i,
    input  logic    bmem_rvalid_i,
    input  beat_t   bmem_rdata_i,
    input  addr_t   bmem_raddr_i,

    output addr_t   bmem_addr_o,
    output logic    bmem_read_o,
    output logic    line_valid_o,
    output line_t   line_o
);

    deser_state_t   state;
    line_tag_t      req_tag;
    logic [1:0]     beat_cnt;
    logic           beat_hit;

    // read goes out in the first cycle the port is ready
    assign bmem_read_o = (state == request) && bmem_ready_i;
    assign bmem_addr_o = {req_tag, 5'b0};

    // beats for some other line are not ours
    assign beat_hit = bmem_rvalid_i && (bmem_raddr_i[31:5] == req_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= idle;
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= 1'b0;
            case (state)
                idle: begin
                    if (start_i) begin
                        state <= request;
                    end
                end
                request: begin
                    beat_cnt <= '0;
                    if (bmem_ready_i) begin
                        state <= collect;
                    end
                end
                collect: begin
                    if (beat_hit) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (beat_cnt == 2'(BEATS_PER_LINE - 1)) begin
                            line_valid_o <= 1'b1;
                            state        <= idle;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // requested line and beat shift register
    always_ff @(posedge clk) begin
        if (state == idle && start_i) begin
            req_tag <= start_addr_i[31:5];
        end
        // beat 0 ends up in the lowest 64 bits after four shifts
        if (state == collect && beat_hit) begin
            line_o <= {bmem_rdata_i, line_o[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

endmodule

// File: design/bmem_arbiter.sv
`timescale 1ns/1ps

module bmem_arbiter
import mem_front_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    load_req_i,
    input  addr_t   load_line_addr_i,
    input  logic    fetch_req_i,
    input  addr_t   fetch_line_addr_i,

    input  logic    line_valid_i,
    input  line_t   line_i,

    output logic    start_o,
    output addr_t   start_addr_o,
    output logic    load_line_valid_o,
    output logic    fetch_line_valid_o,
    output line_t   line_o
);

    grant_t grant;

    // only the owner of the grant sees the line
    assign load_line_valid_o  = line_valid_i && (grant == grant_load);
    assign fetch_line_valid_o = line_valid_i && (grant == grant_fetch);
    assign line_o             = line_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant   <= none;
            start_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (grant == none) begin
                // load wins a tie
                if (load_req_i) begin
                    grant   <= grant_load;
                    start_o <= 1'b1;
                end else if (fetch_req_i) begin
                    grant   <= grant_fetch;
                    start_o <= 1'b1;
                end
            end else if (line_valid_i) begin
                grant <= none;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant == none) begin
            start_addr_o <= load_req_i ? load_line_addr_i : fetch_line_addr_i;
        end
    end

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
import mem_front_pkg::*;
#(
    parameter addr_t RESET_PC = 32'haaaaa000
)
(
    input  logic    clk,
    input  logic    rst,

    input  logic    redirect_valid_i,
    input  addr_t   redirect_pc_i,

    input  logic    line_valid_i,
    input  line_t   line_i,
    input  logic    queue_full_i,

    output logic    line_req_o,
    output addr_t   line_addr_o,

    output logic    push_o,
    output addr_t   push_pc_o,
    output word_t   push_inst_o
);

    addr_t      pc;
    line_t      buf_line;
    line_tag_t  buf_tag;
    logic       buf_valid;
    // burst in flight belongs to a PC that was redirected away
    logic       stale;

    logic       hit;
    word_sel_t  sel;

    assign hit = buf_valid && (pc[31:5] == buf_tag);
    assign sel = pc[4:2];

    // nothing is pushed in the redirect cycle, the queue is being flushed
    assign push_o      = hit && !queue_full_i && !redirect_valid_i;
    assign push_pc_o   = pc;
    assign push_inst_o = buf_line[32*sel +: 32];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            buf_valid  <= 1'b0;
            line_req_o <= 1'b0;
            stale      <= 1'b0;
        end else begin
            if (redirect_valid_i) begin
                pc <= redirect_pc_i;
            end else if (push_o) begin
                pc <= pc + 32'd4;
            end

            if (line_req_o && line_valid_i) begin
                line_req_o <= 1'b0;
                stale      <= 1'b0;
                if (!stale) begin
                    buf_valid <= 1'b1;
                end
            end else if (line_req_o) begin
                if (redirect_valid_i) begin
                    stale <= 1'b1;
                end
            end else if (!hit && !redirect_valid_i) begin
                // miss, ask for the line holding pc
                line_req_o <= 1'b1;
            end
        end
    end

    // line buffer and request address
    always_ff @(posedge clk) begin
        if (line_req_o && line_valid_i && !stale) begin
            buf_line <= line_i;
            buf_tag  <= line_addr_o[31:5];
        end
        if (!line_req_o && !hit && !redirect_valid_i) begin
            line_addr_o <= {pc[31:5], 5'b0};
        end
    end

endmodule

// File: design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
import mem_front_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
)
(
    input  logic    clk,
    input  logic    rst,

    input  logic    flush_i,
    input  logic    push_i,
    input  addr_t   push_pc_i,
    input  word_t   push_inst_i,
    input  logic    inst_ready_i,

    output logic    full_o,
    output logic    inst_valid_o,
    output addr_t   inst_pc_o,
    output word_t   inst_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    addr_t          pc_mem   [QUEUE_DEPTH];
    word_t          inst_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    assign full_o       = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign inst_valid_o = (count != '0);
    assign inst_pc_o    = pc_mem[head];
    assign inst_o       = inst_mem[head];

    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = inst_valid_o && inst_ready_i && !flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[tail]   <= push_pc_i;
            inst_mem[tail] <= push_inst_i;
        end
    end

endmodule

// File: design/load_unit.sv
`timescale 1ns/1ps

module load_unit
import mem_front_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    load_req_valid_i,
    input  addr_t   load_addr_i,
    output logic    load_req_ready_o,

    input  logic    line_valid_i,
    input  line_t   line_i,

    output logic    line_req_o,
    output addr_t   line_addr_o,

    output logic    load_resp_valid_o,
    output word_t   load_data_o
);

    line_t      buf_line;
    line_tag_t  buf_tag;
    logic       buf_valid;
    word_sel_t  sel_q;

    logic       accept;
    logic       hit;
    word_sel_t  sel_in;

    // one load at a time, busy while its line is on the way
    assign load_req_ready_o = !line_req_o;
    assign accept           = load_req_valid_i && load_req_ready_o;
    assign sel_in           = load_addr_i[4:2];
    assign hit              = buf_valid && (load_addr_i[31:5] == buf_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            line_req_o        <= 1'b0;
            buf_valid         <= 1'b0;
            load_resp_valid_o <= 1'b0;
        end else begin
            load_resp_valid_o <= 1'b0;
            if (accept) begin
                if (hit) begin
                    load_resp_valid_o <= 1'b1;
                end else begin
                    line_req_o <= 1'b1;
                end
            end else if (line_req_o && line_valid_i) begin
                line_req_o        <= 1'b0;
                buf_valid         <= 1'b1;
                load_resp_valid_o <= 1'b1;
            end
        end
    end

    // payload side, address latch and line buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            sel_q       <= sel_in;
            line_addr_o <= {load_addr_i[31:5], 5'b0};
            load_data_o <= buf_line[32*sel_in +: 32];
        end else if (line_req_o && line_valid_i) begin
            buf_line    <= line_i;
            buf_tag     <= line_addr_o[31:5];
            // answer straight from the incoming line
            load_data_o <= line_i[32*sel_q +: 32];
        end
    end

endmodule

// File: design/mem_front_top.sv
`timescale 1ns/1ps

module mem_front_top
import mem_front_pkg::*;
#(
    parameter addr_t RESET_PC    = 32'haaaaa000,
    parameter int    QUEUE_DEPTH = 16
)
(
    input  logic    clk,
    input  logic    rst,

    output addr_t   bmem_addr_o,
    output logic    bmem_read_o,
    input  logic    bmem_ready_i,
    input  addr_t   bmem_raddr_i,
    input  beat_t   bmem_rdata_i,
    input  logic    bmem_rvalid_i,

    input  logic    redirect_valid_i,
    input  addr_t   redirect_pc_i,

    output logic    inst_valid_o,
    input  logic    inst_ready_i,
    output addr_t   inst_pc_o,
    output word_t   inst_o,

    input  logic    load_req_valid_i,
    output logic    load_req_ready_o,
    input  addr_t   load_addr_i,

    output logic    load_resp_valid_o,
    output word_t   load_data_o
);

    // fetch side
    logic   fetch_req;
    addr_t  fetch_line_addr;
    logic   fetch_line_valid;
    logic   push;
    addr_t  push_pc;
    word_t  push_inst;
    logic   queue_full;

    // load side
    logic   load_req;
    addr_t  load_line_addr;
    logic   load_line_valid;

    // shared port
    logic   start;
    addr_t  start_addr;
    logic   line_valid;
    line_t  deser_line;
    line_t  routed_line;

    fetch_unit #(
        .RESET_PC           (RESET_PC)
    ) fetch_unit_inst (
        .clk                (clk),
        .rst                (rst),
        .redirect_valid_i   (redirect_valid_i),
        .redirect_pc_i      (redirect_pc_i),
        .line_valid_i       (fetch_line_valid),
        .line_i             (routed_line),
        .queue_full_i       (queue_full),
        .line_req_o         (fetch_req),
        .line_addr_o        (fetch_line_addr),
        .push_o             (push),
        .push_pc_o          (push_pc),
        .push_inst_o        (push_inst)
    );

    fetch_queue #(
        .QUEUE_DEPTH        (QUEUE_DEPTH)
    ) fetch_queue_inst (
        .clk                (clk),
        .rst                (rst),
        .flush_i            (redirect_valid_i),
        .push_i             (push),
        .push_pc_i          (push_pc),
        .push_inst_i        (push_inst),
        .inst_ready_i       (inst_ready_i),
        .full_o             (queue_full),
        .inst_valid_o       (inst_valid_o),
        .inst_pc_o          (inst_pc_o),
        .inst_o             (inst_o)
    );

    load_unit load_unit_inst (
        .clk                (clk),
        .rst                (rst),
        .load_req_valid_i   (load_req_valid_i),
        .load_addr_i        (load_addr_i),
        .load_req_ready_o   (load_req_ready_o),
        .line_valid_i       (load_line_valid),
        .line_i             (routed_line),
        .line_req_o         (load_req),
        .line_addr_o        (load_line_addr),
        .load_resp_valid_o  (load_resp_valid_o),
        .load_data_o        (load_data_o)
    );

    bmem_arbiter bmem_arbiter_inst (
        .clk                (clk),
        .rst                (rst),
        .load_req_i         (load_req),
        .load_line_addr_i   (load_line_addr),
        .fetch_req_i        (fetch_req),
        .fetch_line_addr_i  (fetch_line_addr),
        .line_valid_i       (line_valid),
        .line_i             (deser_line),
        .start_o            (start),
        .start_addr_o       (start_addr),
        .load_line_valid_o  (load_line_valid),
        .fetch_line_valid_o (fetch_line_valid),
        .line_o             (routed_line)
    );

    burst_deserializer burst_deserializer_inst (
        .clk                (clk),
        .rst                (rst),
        .start_i            (start),
        .start_addr_i       (start_addr),
        .bmem_ready_i       (bmem_ready_i),
        .bmem_rvalid_i      (bmem_rvalid_i),
        .bmem_rdata_i       (bmem_rdata_i),
        .bmem_raddr_i       (bmem_raddr_i),
        .bmem_addr_o        (bmem_addr_o),
        .bmem_read_o        (bmem_read_o),
        .line_valid_o       (line_valid),
        .line_o             (deser_line)
    );

endmodule

// File: verif/bmem_model.sv
`timescale 1ns/1ps

module bmem_model
import mem_front_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        read_i,
    input  addr_t       addr_i,
    input  logic [1:0]  gap_i,
    output logic        ready_o,
    output addr_t       raddr_o,
    output beat_t       rdata_o,
    output logic        rvalid_o
);

    logic       ready_q   = 1'b0;
    logic       rvalid_q  = 1'b0;
    addr_t      raddr_q   = '0;
    beat_t      rdata_q   = '0;
    logic       busy      = 1'b0;
    logic [1:0] beat      = '0;
    logic [1:0] gap       = '0;
    addr_t      line_addr = '0;

    // memory content: address with its upper half inverted
    function automatic word_t word_at(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    assign ready_o  = ready_q;
    assign rvalid_o = rvalid_q;
    assign raddr_o  = raddr_q;
    assign rdata_o  = rdata_q;

    always @(posedge clk) begin
        if (rst) begin
            ready_q  <= 1'b1;
            rvalid_q <= 1'b0;
            busy     <= 1'b0;
            beat     <= '0;
            gap      <= '0;
        end else begin
            rvalid_q <= 1'b0;
            if (read_i && ready_q) begin
                ready_q   <= 1'b0;
                busy      <= 1'b1;
                beat      <= '0;
                line_addr <= {addr_i[31:5], 5'b0};
            end else if (busy) begin
                // beat k carries words 2k and 2k+1
                rvalid_q <= 1'b1;
                raddr_q  <= line_addr;
                rdata_q  <= {word_at(line_addr + {27'h0, beat, 3'b100}),
                             word_at(line_addr + {27'h0, beat, 3'b000})};
                beat     <= beat + 2'd1;
                if (beat == 2'd3) begin
                    busy <= 1'b0;
                    gap  <= gap_i;
                end
            end else if (!ready_q) begin
                // port stays busy for a few idle cycles after a burst
                if (gap == 2'd0) begin
                    ready_q <= 1'b1;
                end else begin
                    gap <= gap - 2'd1;
                end
            end
        end
    end

endmodule

// File: verif/tb_mem_front.sv
`timescale 1ns/1ps

module tb_mem_front
import mem_front_pkg::*;
();

    localparam addr_t RESET_PC    = 32'haaaaa000;
    localparam int    QUEUE_DEPTH = 16;
    localparam int    MAX_CYCLES  = 4000;
    localparam addr_t LOAD_BASE   = 32'h20000000;
    localparam addr_t REUSE_PC    = 32'h00004000;

    logic        clk = 1'b0;
    logic        rst;
    logic        redirect_valid;
    addr_t       redirect_pc;
    logic        inst_valid;
    logic        inst_ready;
    addr_t       inst_pc;
    word_t       inst;
    logic        load_req_valid;
    logic        load_req_ready;
    addr_t       load_addr;
    logic        load_resp_valid;
    word_t       load_data;
    addr_t       bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    addr_t       bmem_raddr;
    beat_t       bmem_rdata;
    logic        bmem_rvalid;
    logic [1:0]  ready_gap;

    // scoreboard state
    logic        fire;
    logic        first_pending;
    logic        have_last;
    logic        after_redirect;
    addr_t       last_pc;
    addr_t       redirect_target;
    logic        load_pending;
    addr_t       load_addr_q;
    logic [2:0]  beats_left;
    logic        window_active;
    logic        window_done;
    int          window_fires;
    int          window_reads;
    int          inst_count;
    int          load_count;
    int          idle_cycles;
    int          cycle_count = 0;
    logic [31:0] rand_state = 32'd1345;

    always #4 clk = ~clk;

    mem_front_top #(
        .RESET_PC           (RESET_PC),
        .QUEUE_DEPTH        (QUEUE_DEPTH)
    ) mem_front_top_inst (
        .clk                (clk),
        .rst                (rst),
        .bmem_addr_o        (bmem_addr),
        .bmem_read_o        (bmem_read),
        .bmem_ready_i       (bmem_ready),
        .bmem_raddr_i       (bmem_raddr),
        .bmem_rdata_i       (bmem_rdata),
        .bmem_rvalid_i      (bmem_rvalid),
        .redirect_valid_i   (redirect_valid),
        .redirect_pc_i      (redirect_pc),
        .inst_valid_o       (inst_valid),
        .inst_ready_i       (inst_ready),
        .inst_pc_o          (inst_pc),
        .inst_o             (inst),
        .load_req_valid_i   (load_req_valid),
        .load_req_ready_o   (load_req_ready),
        .load_addr_i        (load_addr),
        .load_resp_valid_o  (load_resp_valid),
        .load_data_o        (load_data)
    );

    bmem_model bmem_model_inst (
        .clk      (clk),
        .rst      (rst),
        .read_i   (bmem_read),
        .addr_i   (bmem_addr),
        .gap_i    (ready_gap),
        .ready_o  (bmem_ready),
        .raddr_o  (bmem_raddr),
        .rdata_o  (bmem_rdata),
        .rvalid_o (bmem_rvalid)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // expected memory word at a byte address
    function automatic word_t expected_word(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // one cycle of random traffic, or a quiet cycle
    task automatic drive_cycle(input logic traffic_on);
        logic [31:0] r;
        @(posedge clk);
        r = next_rand();
        ready_gap <= r[1:0];
        // a load stays presented until it is taken
        if (!load_req_valid || load_req_ready) begin
            if (traffic_on && r[5:4] == 2'b00) begin
                load_req_valid <= 1'b1;
                load_addr      <= LOAD_BASE | {24'h0, r[31:24]};
            end else begin
                load_req_valid <= 1'b0;
            end
        end
        if (traffic_on && !redirect_valid && inst_count >= 4 && r[14:8] == 7'h00) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= {16'h0001, r[31:18], 2'b00};
            inst_ready     <= 1'b0;
        end else begin
            redirect_valid <= 1'b0;
            inst_ready     <= traffic_on && (r[2] | r[3]);
        end
    endtask

    assign fire = inst_valid && inst_ready;

    always @(posedge clk) begin
        if (rst) begin
            first_pending  <= 1'b1;
            have_last      <= 1'b0;
            after_redirect <= 1'b0;
            load_pending   <= 1'b0;
            beats_left     <= 3'd0;
            window_active  <= 1'b0;
            window_done    <= 1'b0;
            inst_count     <= 0;
            load_count     <= 0;
            idle_cycles    <= 0;
        end else begin
            if (redirect_valid) begin
                have_last       <= 1'b0;
                after_redirect  <= 1'b1;
                first_pending   <= 1'b0;
                redirect_target <= redirect_pc;
            end else if (fire) begin
                last_pc        <= inst_pc;
                have_last      <= 1'b1;
                after_redirect <= 1'b0;
                first_pending  <= 1'b0;
                inst_count     <= inst_count + 1;
            end
            if (load_req_valid && load_req_ready) begin
                load_pending <= 1'b1;
                load_addr_q  <= load_addr;
            end else if (load_resp_valid) begin
                load_pending <= 1'b0;
            end
            if (load_resp_valid) begin
                load_count <= load_count + 1;
            end
            if (bmem_read) begin
                beats_left <= 3'd4;
            end else if (bmem_rvalid && beats_left != 3'd0) begin
                beats_left <= beats_left - 3'd1;
            end
            idle_cycles <= (bmem_read || beats_left != 3'd0) ? 0 : idle_cycles + 1;
            // line reuse window opens on the redirect to the aligned PC
            if (redirect_valid && redirect_pc == REUSE_PC) begin
                window_active <= 1'b1;
                window_fires  <= 0;
                window_reads  <= 0;
            end else if (window_active) begin
                if (bmem_read) begin
                    window_reads <= window_reads + 1;
                end
                if (fire) begin
                    window_fires <= window_fires + 1;
                    if (window_fires == 7) begin
                        window_active <= 1'b0;
                        window_done   <= 1'b1;
                    end
                end
            end
        end
    end

    inst_word_check: assert property (@(posedge clk) disable iff (rst)
        fire |-> inst == expected_word(inst_pc))
        else stop_on_error($sformatf("MISMATCH at %0t: instruction %h at pc %h",
            $time, $sampled(inst), $sampled(inst_pc)));

    first_pc_check: assert property (@(posedge clk) disable iff (rst)
        fire && first_pending |-> inst_pc == RESET_PC)
        else stop_on_error($sformatf("MISMATCH at %0t: first pc %h after reset",
            $time, $sampled(inst_pc)));

    sequential_pc_check: assert property (@(posedge clk) disable iff (rst)
        fire && have_last |-> inst_pc == last_pc + 32'd4)
        else stop_on_error($sformatf("MISMATCH at %0t: pc %h does not follow %h",
            $time, $sampled(inst_pc), $sampled(last_pc)));

    redirect_bubble_check: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !inst_valid)
        else stop_on_error("instruction output still valid in the cycle after a redirect");

    redirect_pc_check: assert property (@(posedge clk) disable iff (rst)
        fire && after_redirect |-> inst_pc == redirect_target)
        else stop_on_error($sformatf("MISMATCH at %0t: pc %h after redirect to %h",
            $time, $sampled(inst_pc), $sampled(redirect_target)));

    load_data_check: assert property (@(posedge clk) disable iff (rst)
        load_resp_valid |-> load_data == expected_word({load_addr_q[31:2], 2'b00}))
        else stop_on_error($sformatf("MISMATCH at %0t: load data %h for address %h",
            $time, $sampled(load_data), $sampled(load_addr_q)));

    load_busy_check: assert property (@(posedge clk) disable iff (rst)
        load_pending && !load_resp_valid |-> !load_req_ready)
        else stop_on_error("load port ready while a load is still outstanding");

    read_pulse_check: assert property (@(posedge clk) disable iff (rst)
        bmem_read |-> bmem_addr[4:0] == 5'd0 && bmem_ready)
        else stop_on_error("burst read unaligned or issued while the port was not ready");

    read_overlap_check: assert property (@(posedge clk) disable iff (rst)
        bmem_read |-> beats_left == 3'd0)
        else stop_on_error("second burst read issued before four beats returned");

    line_reuse_check: assert property (@(posedge clk) disable iff (rst)
        fire && window_active && window_fires == 7 |->
            window_reads + int'(bmem_read) == 1)
        else stop_on_error("eight instructions from one line did not take exactly one burst");

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_on_error($sformatf("timeout, run did not finish within %0d cycles",
                MAX_CYCLES));
        end
    end

    initial begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        inst_ready     = 1'b0;
        load_req_valid = 1'b0;
        load_addr      = '0;
        ready_gap      = 2'd0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // mixed fetch, load and redirect traffic
        while (inst_count < 200 || load_count < 40) begin
            drive_cycle(1'b1);
        end

        // let the memory side go idle before the line reuse test
        while (idle_cycles < 32 || load_req_valid || load_pending) begin
            drive_cycle(1'b0);
        end

        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= REUSE_PC;
        inst_ready     <= 1'b0;
        @(posedge clk);
        redirect_valid <= 1'b0;
        inst_ready     <= 1'b1;
        while (!window_done) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: build.f
design/mem_front_pkg.sv
design/burst_deserializer.sv
design/bmem_arbiter.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/load_unit.sv
design/mem_front_top.sv
verif/bmem_model.sv
verif/tb_mem_front.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f build.f --top-module tb_mem_front \
    -Mdir obj_dir > build.log 2>&1 &&
    ./obj_dir/Vtb_mem_front > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null &&
    { echo "PASS"; exit 0; } ||
    { echo "FAIL: see build.log and sim.log"; exit 1; }
